/* common/axis_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface axis_if #(
  parameter int unsigned DATA_WIDTH = roce_pkg::AXIS_DATA_WIDTH
);

  logic [DATA_WIDTH-1:0]   tdata;
  logic [DATA_WIDTH/8-1:0] tkeep;
  logic                    tvalid;
  logic                    tlast;
  logic                    tready;

  // side that produces beats
  modport src (
    output tdata, tkeep, tvalid, tlast,
    input  tready
  );

  // side that consumes beats
  modport snk (
    input  tdata, tkeep, tvalid, tlast,
    output tready
  );

endinterface

`default_nettype wire

/* common/roce_pkg.sv */
`default_nettype none

package roce_pkg;

  // stream and register widths
  localparam int unsigned AXIS_DATA_WIDTH = 512;
  localparam int unsigned CSR_ADDR_WIDTH = 8;
  localparam int unsigned CSR_DATA_WIDTH = 32;
  localparam int unsigned COUNT_WIDTH = 32;

  // tx arbiter grant state
  typedef enum logic [1:0] {
    IDLE         = 2'd0,
    GRANT_ROCE   = 2'd1,
    GRANT_BYPASS = 2'd2
  } arb_state_e;

  // register map, byte addresses
  typedef enum logic [7:0] {
    // bit 0 enables roce transmission
    CONF       = 8'h00,
    MAC_LO     = 8'h04,
    // upper 16 bits of the mac in 15:0
    MAC_HI     = 8'h08,
    IPV4       = 8'h0C,
    CNT_ROCE   = 8'h10,
    CNT_BYPASS = 8'h14,
    // write 1 to bit 0 to zero both counters
    CNT_CLEAR  = 8'h18
  } csr_addr_e;

  // register port response codes
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

endpackage

`default_nettype wire

/* list.f */
common/roce_pkg.sv
common/axis_if.sv
tx_path/tx_arbiter_fsm.sv
tx_path/tx_stream_mux.sv
source/tx_packet_counter.sv
source/csr_regs.sv
source/roce_tx_top.sv
tb/tb_roce_tx_top.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator, result decided from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_roce_tx_top -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "Errors found" >> sim.log
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

/* source/csr_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module csr_regs (
  input  logic                                axis_aclk_i,
  input  logic                                axis_rstn_i,
  input  logic                                s_csr_wvalid_i,
  input  logic [roce_pkg::CSR_ADDR_WIDTH-1:0] s_csr_waddr_i,
  input  logic [roce_pkg::CSR_DATA_WIDTH-1:0] s_csr_wdata_i,
  output logic                                s_csr_wready_o,
  output logic                                s_csr_bvalid_o,
  output logic [1:0]                          s_csr_bresp_o,
  input  logic                                s_csr_bready_i,
  input  logic                                s_csr_arvalid_i,
  input  logic [roce_pkg::CSR_ADDR_WIDTH-1:0] s_csr_araddr_i,
  output logic                                s_csr_arready_o,
  output logic                                s_csr_rvalid_o,
  output logic [roce_pkg::CSR_DATA_WIDTH-1:0] s_csr_rdata_o,
  output logic [1:0]                          s_csr_rresp_o,
  input  logic                                s_csr_rready_i,
  input  logic [roce_pkg::COUNT_WIDTH-1:0]    roce_cnt_i,
  input  logic [roce_pkg::COUNT_WIDTH-1:0]    bypass_cnt_i,
  output logic                                roce_tx_en_o,
  output logic                                clear_o,
  output logic [47:0]                         my_mac_net_o,
  output logic [31:0]                         my_ip_net_o
);

  logic                                wr_en;
  logic                                rd_en;
  logic                                wr_ok;
  logic                                conf_en_q;
  logic [47:0]                         mac_q;
  logic [31:0]                         ip_q;
  logic                                bvalid_q;
  logic                                rvalid_q;
  logic                                clear_q;
  roce_pkg::resp_e                     bresp_q;
  roce_pkg::resp_e                     rresp_q;
  roce_pkg::resp_e                     rresp_d;
  logic [roce_pkg::CSR_DATA_WIDTH-1:0] rdata_q;
  logic [roce_pkg::CSR_DATA_WIDTH-1:0] rdata_d;

  // one outstanding response per channel
  assign wr_en = s_csr_wvalid_i & ~bvalid_q;
  assign rd_en = s_csr_arvalid_i & ~rvalid_q;

  // counters are read only
  always_comb begin
    case (s_csr_waddr_i)
      roce_pkg::CONF,
      roce_pkg::MAC_LO,
      roce_pkg::MAC_HI,
      roce_pkg::IPV4,
      roce_pkg::CNT_CLEAR: wr_ok = 1'b1;
      default:             wr_ok = 1'b0;
    endcase
  end

  always_comb begin
    rresp_d = roce_pkg::OKAY;
    case (s_csr_araddr_i)
      roce_pkg::CONF:       rdata_d = {31'd0, conf_en_q};
      roce_pkg::MAC_LO:     rdata_d = mac_q[31:0];
      roce_pkg::MAC_HI:     rdata_d = {16'd0, mac_q[47:32]};
      roce_pkg::IPV4:       rdata_d = ip_q;
      roce_pkg::CNT_ROCE:   rdata_d = roce_cnt_i;
      roce_pkg::CNT_BYPASS: rdata_d = bypass_cnt_i;
      roce_pkg::CNT_CLEAR:  rdata_d = '0;
      default: begin
        rdata_d = '0;
        rresp_d = roce_pkg::SLVERR;
      end
    endcase
  end

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      conf_en_q <= 1'b0;
      mac_q     <= '0;
      ip_q      <= '0;
      bvalid_q  <= 1'b0;
      rvalid_q  <= 1'b0;
      clear_q   <= 1'b0;
    end else begin
      clear_q <= wr_en & (s_csr_waddr_i == roce_pkg::CNT_CLEAR) & s_csr_wdata_i[0];
      if (wr_en) begin
        case (s_csr_waddr_i)
          roce_pkg::CONF:   conf_en_q     <= s_csr_wdata_i[0];
          roce_pkg::MAC_LO: mac_q[31:0]   <= s_csr_wdata_i;
          roce_pkg::MAC_HI: mac_q[47:32]  <= s_csr_wdata_i[15:0];
          roce_pkg::IPV4:   ip_q          <= s_csr_wdata_i;
          default: ;
        endcase
      end
      if (wr_en) begin
        bvalid_q <= 1'b1;
      end else if (s_csr_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_en) begin
        rvalid_q <= 1'b1;
      end else if (s_csr_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge axis_aclk_i) begin
    if (wr_en) begin
      bresp_q <= wr_ok ? roce_pkg::OKAY : roce_pkg::SLVERR;
    end
    if (rd_en) begin
      rdata_q <= rdata_d;
      rresp_q <= rresp_d;
    end
  end

  // low register byte goes first on the wire
  always_comb begin
    for (int i = 0; i < 6; i++) begin
      my_mac_net_o[8*(5-i) +: 8] = mac_q[8*i +: 8];
    end
    for (int j = 0; j < 4; j++) begin
      my_ip_net_o[8*(3-j) +: 8] = ip_q[8*j +: 8];
    end
  end

  assign s_csr_wready_o  = ~bvalid_q;
  assign s_csr_arready_o = ~rvalid_q;
  assign s_csr_bvalid_o  = bvalid_q;
  assign s_csr_bresp_o   = bresp_q;
  assign s_csr_rvalid_o  = rvalid_q;
  assign s_csr_rdata_o   = rdata_q;
  assign s_csr_rresp_o   = rresp_q;
  assign roce_tx_en_o    = conf_en_q;
  assign clear_o         = clear_q;

endmodule

`default_nettype wire

/* source/roce_tx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module roce_tx_top #(
  parameter int unsigned DATA_WIDTH = roce_pkg::AXIS_DATA_WIDTH
)(
  input  logic                                axis_aclk_i,
  input  logic                                axis_rstn_i,

  // tx stream from the roce engine
  input  logic [DATA_WIDTH-1:0]               s_roce_tdata_i,
  input  logic [DATA_WIDTH/8-1:0]             s_roce_tkeep_i,
  input  logic                                s_roce_tvalid_i,
  input  logic                                s_roce_tlast_i,
  output logic                                s_roce_tready_o,

  // non-roce packets
  input  logic [DATA_WIDTH-1:0]               s_bypass_tdata_i,
  input  logic [DATA_WIDTH/8-1:0]             s_bypass_tkeep_i,
  input  logic                                s_bypass_tvalid_i,
  input  logic                                s_bypass_tlast_i,
  output logic                                s_bypass_tready_o,

  // merged stream toward the mac
  output logic [DATA_WIDTH-1:0]               m_eth_tdata_o,
  output logic [DATA_WIDTH/8-1:0]             m_eth_tkeep_o,
  output logic                                m_eth_tvalid_o,
  output logic                                m_eth_tlast_o,
  input  logic                                m_eth_tready_i,

  input  logic                                s_csr_wvalid_i,
  input  logic [roce_pkg::CSR_ADDR_WIDTH-1:0] s_csr_waddr_i,
  input  logic [roce_pkg::CSR_DATA_WIDTH-1:0] s_csr_wdata_i,
  output logic                                s_csr_wready_o,
  output logic                                s_csr_bvalid_o,
  output logic [1:0]                          s_csr_bresp_o,
  input  logic                                s_csr_bready_i,
  input  logic                                s_csr_arvalid_i,
  input  logic [roce_pkg::CSR_ADDR_WIDTH-1:0] s_csr_araddr_i,
  output logic                                s_csr_arready_o,
  output logic                                s_csr_rvalid_o,
  output logic [roce_pkg::CSR_DATA_WIDTH-1:0] s_csr_rdata_o,
  output logic [1:0]                          s_csr_rresp_o,
  input  logic                                s_csr_rready_i,

  output logic [47:0]                         my_mac_net_o,
  output logic [31:0]                         my_ip_net_o
);

  roce_pkg::arb_state_e             grant;
  logic                             pkt_done;
  logic                             roce_tx_en;
  logic                             cnt_clear;
  logic [roce_pkg::COUNT_WIDTH-1:0] roce_cnt;
  logic [roce_pkg::COUNT_WIDTH-1:0] bypass_cnt;

  axis_if #(.DATA_WIDTH(DATA_WIDTH)) roce_tx ();
  axis_if #(.DATA_WIDTH(DATA_WIDTH)) bypass_tx ();
  axis_if #(.DATA_WIDTH(DATA_WIDTH)) eth_tx ();

  assign roce_tx.tdata     = s_roce_tdata_i;
  assign roce_tx.tkeep     = s_roce_tkeep_i;
  assign roce_tx.tvalid    = s_roce_tvalid_i;
  assign roce_tx.tlast     = s_roce_tlast_i;
  assign s_roce_tready_o   = roce_tx.tready;

  assign bypass_tx.tdata   = s_bypass_tdata_i;
  assign bypass_tx.tkeep   = s_bypass_tkeep_i;
  assign bypass_tx.tvalid  = s_bypass_tvalid_i;
  assign bypass_tx.tlast   = s_bypass_tlast_i;
  assign s_bypass_tready_o = bypass_tx.tready;

  assign m_eth_tdata_o     = eth_tx.tdata;
  assign m_eth_tkeep_o     = eth_tx.tkeep;
  assign m_eth_tvalid_o    = eth_tx.tvalid;
  assign m_eth_tlast_o     = eth_tx.tlast;
  assign eth_tx.tready     = m_eth_tready_i;

  tx_arbiter_fsm #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_tx_arbiter_fsm (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .roce_i      (roce_tx),
    .bypass_i    (bypass_tx),
    .eth_i       (eth_tx),
    .roce_tx_en_i(roce_tx_en),
    .grant_o     (grant),
    .pkt_done_o  (pkt_done)
  );

  tx_stream_mux #(
    .DATA_WIDTH(DATA_WIDTH)
  ) u_tx_stream_mux (
    .grant_i (grant),
    .roce_s  (roce_tx),
    .bypass_s(bypass_tx),
    .eth_m   (eth_tx)
  );

  tx_packet_counter u_tx_packet_counter (
    .axis_aclk_i (axis_aclk_i),
    .axis_rstn_i (axis_rstn_i),
    .grant_i     (grant),
    .pkt_done_i  (pkt_done),
    .clear_i     (cnt_clear),
    .roce_cnt_o  (roce_cnt),
    .bypass_cnt_o(bypass_cnt)
  );

  csr_regs u_csr_regs (
    .axis_aclk_i    (axis_aclk_i),
    .axis_rstn_i    (axis_rstn_i),
    .s_csr_wvalid_i (s_csr_wvalid_i),
    .s_csr_waddr_i  (s_csr_waddr_i),
    .s_csr_wdata_i  (s_csr_wdata_i),
    .s_csr_wready_o (s_csr_wready_o),
    .s_csr_bvalid_o (s_csr_bvalid_o),
    .s_csr_bresp_o  (s_csr_bresp_o),
    .s_csr_bready_i (s_csr_bready_i),
    .s_csr_arvalid_i(s_csr_arvalid_i),
    .s_csr_araddr_i (s_csr_araddr_i),
    .s_csr_arready_o(s_csr_arready_o),
    .s_csr_rvalid_o (s_csr_rvalid_o),
    .s_csr_rdata_o  (s_csr_rdata_o),
    .s_csr_rresp_o  (s_csr_rresp_o),
    .s_csr_rready_i (s_csr_rready_i),
    .roce_cnt_i     (roce_cnt),
    .bypass_cnt_i   (bypass_cnt),
    .roce_tx_en_o   (roce_tx_en),
    .clear_o        (cnt_clear),
    .my_mac_net_o   (my_mac_net_o),
    .my_ip_net_o    (my_ip_net_o)
  );

endmodule

`default_nettype wire

/* source/tx_packet_counter.sv */
`timescale 1ns/1ns
`default_nettype none

module tx_packet_counter (
  input  logic                             axis_aclk_i,
  input  logic                             axis_rstn_i,
  input  roce_pkg::arb_state_e             grant_i,
  input  logic                             pkt_done_i,
  input  logic                             clear_i,
  output logic [roce_pkg::COUNT_WIDTH-1:0] roce_cnt_o,
  output logic [roce_pkg::COUNT_WIDTH-1:0] bypass_cnt_o
);

  logic [roce_pkg::COUNT_WIDTH-1:0] roce_cnt_q;
  logic [roce_pkg::COUNT_WIDTH-1:0] bypass_cnt_q;
  logic                             roce_inc;
  logic                             bypass_inc;

  // grant is still held on the cycle the last beat goes out
  assign roce_inc   = pkt_done_i & (grant_i == roce_pkg::GRANT_ROCE);
  assign bypass_inc = pkt_done_i & (grant_i == roce_pkg::GRANT_BYPASS);

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      roce_cnt_q   <= '0;
      bypass_cnt_q <= '0;
    end else if (clear_i) begin
      roce_cnt_q   <= '0;
      bypass_cnt_q <= '0;
    end else begin
      // free running, wraps at full scale
      if (roce_inc) begin
        roce_cnt_q <= roce_cnt_q + 1'b1;
      end
      if (bypass_inc) begin
        bypass_cnt_q <= bypass_cnt_q + 1'b1;
      end
    end
  end

  assign roce_cnt_o   = roce_cnt_q;
  assign bypass_cnt_o = bypass_cnt_q;

endmodule

`default_nettype wire

/* tb/tb_roce_tx_top.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_roce_tx_top;

  localparam int DATA_WIDTH = 64;
  localparam int KEEP_WIDTH = DATA_WIDTH / 8;
  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 8;
  // rough cycle budget of each test
  localparam int REG_CYCLES = 80;
  localparam int BYPASS_CYCLES = 50;
  localparam int RR_CYCLES = 90;
  localparam int BP_CYCLES = 250;
  localparam int CNT_CYCLES = 30;
  localparam int LIMIT_CYCLES = RESET_CYCLES + 2 * (REG_CYCLES + BYPASS_CYCLES + RR_CYCLES
                                + BP_CYCLES + CNT_CYCLES) + 100;

  typedef logic [DATA_WIDTH+KEEP_WIDTH:0] beat_t;

  logic                    clk = 1'b0;
  logic                    rstn;
  logic [DATA_WIDTH-1:0]   s_roce_tdata_i;
  logic [KEEP_WIDTH-1:0]   s_roce_tkeep_i;
  logic                    s_roce_tvalid_i;
  logic                    s_roce_tlast_i;
  logic                    s_roce_tready_o;
  logic [DATA_WIDTH-1:0]   s_bypass_tdata_i;
  logic [KEEP_WIDTH-1:0]   s_bypass_tkeep_i;
  logic                    s_bypass_tvalid_i;
  logic                    s_bypass_tlast_i;
  logic                    s_bypass_tready_o;
  logic [DATA_WIDTH-1:0]   m_eth_tdata_o;
  logic [KEEP_WIDTH-1:0]   m_eth_tkeep_o;
  logic                    m_eth_tvalid_o;
  logic                    m_eth_tlast_o;
  logic                    m_eth_tready_i = 1'b1;
  logic                    s_csr_wvalid_i;
  logic [7:0]              s_csr_waddr_i;
  logic [31:0]             s_csr_wdata_i;
  logic                    s_csr_wready_o;
  logic                    s_csr_bvalid_o;
  logic [1:0]              s_csr_bresp_o;
  logic                    s_csr_bready_i;
  logic                    s_csr_arvalid_i;
  logic [7:0]              s_csr_araddr_i;
  logic                    s_csr_arready_o;
  logic                    s_csr_rvalid_o;
  logic [31:0]             s_csr_rdata_o;
  logic [1:0]              s_csr_rresp_o;
  logic                    s_csr_rready_i;
  logic [47:0]             my_mac_net_o;
  logic [31:0]             my_ip_net_o;

  int    seed;
  int    rnd;
  bit    random_ready;
  bit    roce_hold;
  int    errors;
  int    checks;
  int    tests;
  int    mon_errors;
  int    mon_checks;
  int    sent_roce;
  int    sent_bypass;
  bit    in_pkt;
  int    cur_src;
  beat_t exp_roce[$];
  beat_t exp_bypass[$];
  int    pkt_order[$];

  roce_tx_top #(.DATA_WIDTH(DATA_WIDTH)) uut (
    .axis_aclk_i(clk), .axis_rstn_i(rstn),
    .s_roce_tdata_i(s_roce_tdata_i), .s_roce_tkeep_i(s_roce_tkeep_i),
    .s_roce_tvalid_i(s_roce_tvalid_i), .s_roce_tlast_i(s_roce_tlast_i),
    .s_roce_tready_o(s_roce_tready_o),
    .s_bypass_tdata_i(s_bypass_tdata_i), .s_bypass_tkeep_i(s_bypass_tkeep_i),
    .s_bypass_tvalid_i(s_bypass_tvalid_i), .s_bypass_tlast_i(s_bypass_tlast_i),
    .s_bypass_tready_o(s_bypass_tready_o),
    .m_eth_tdata_o(m_eth_tdata_o), .m_eth_tkeep_o(m_eth_tkeep_o),
    .m_eth_tvalid_o(m_eth_tvalid_o), .m_eth_tlast_o(m_eth_tlast_o),
    .m_eth_tready_i(m_eth_tready_i),
    .s_csr_wvalid_i(s_csr_wvalid_i), .s_csr_waddr_i(s_csr_waddr_i),
    .s_csr_wdata_i(s_csr_wdata_i), .s_csr_wready_o(s_csr_wready_o),
    .s_csr_bvalid_o(s_csr_bvalid_o), .s_csr_bresp_o(s_csr_bresp_o),
    .s_csr_bready_i(s_csr_bready_i),
    .s_csr_arvalid_i(s_csr_arvalid_i), .s_csr_araddr_i(s_csr_araddr_i),
    .s_csr_arready_o(s_csr_arready_o), .s_csr_rvalid_o(s_csr_rvalid_o),
    .s_csr_rdata_o(s_csr_rdata_o), .s_csr_rresp_o(s_csr_rresp_o),
    .s_csr_rready_i(s_csr_rready_i),
    .my_mac_net_o(my_mac_net_o), .my_ip_net_o(my_ip_net_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // eth sink with ready either random or always high
  always @(posedge clk) begin
    #5;
    rnd = $random(seed);
    m_eth_tready_i = random_ready ? rnd[0] : 1'b1;
  end

  function automatic logic [DATA_WIDTH-1:0] beat_data(input int src, input int pkt,
                                                      input int beat);
    logic [7:0] tag;
    tag = (src == 0) ? 8'hC0 : 8'hB1;
    beat_data = {tag, pkt[7:0], beat[7:0], 8'h00, pkt[15:0] ^ 16'h5A5A, beat[15:0] ^ 16'h3C3C};
  endfunction

  function automatic logic [KEEP_WIDTH-1:0] beat_keep(input int pkt, input logic last);
    beat_keep = last ? ({KEEP_WIDTH{1'b1}} >> (pkt % 4)) : {KEEP_WIDTH{1'b1}};
  endfunction

  function automatic int pkt_len(input int src, input int pkt);
    pkt_len = ((pkt * 3 + src) % 4) + 1;
  endfunction

  function automatic int error_total();
    error_total = errors + mon_errors;
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Fail %0t: %s", $time, msg);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clk);
    #5;
  endtask

  task automatic set_source(input int src, input logic [DATA_WIDTH-1:0] data,
                            input logic [KEEP_WIDTH-1:0] keep, input logic valid,
                            input logic last);
    if (src == 0) begin
      s_roce_tdata_i  = data;
      s_roce_tkeep_i  = keep;
      s_roce_tvalid_i = valid;
      s_roce_tlast_i  = last;
    end else begin
      s_bypass_tdata_i  = data;
      s_bypass_tkeep_i  = keep;
      s_bypass_tvalid_i = valid;
      s_bypass_tlast_i  = last;
    end
  endtask

  // expected beats per source in send order
  task automatic queue_packets(input int src, input int first_pkt, input int npkts);
    int   len;
    logic last;
    for (int p = first_pkt; p < first_pkt + npkts; p++) begin
      len = pkt_len(src, p);
      for (int b = 0; b < len; b++) begin
        last = (b == len - 1);
        if (src == 0) exp_roce.push_back({last, beat_keep(p, last), beat_data(src, p, b)});
        else exp_bypass.push_back({last, beat_keep(p, last), beat_data(src, p, b)});
      end
    end
    if (src == 0) sent_roce += npkts;
    else sent_bypass += npkts;
  endtask

  task automatic drive_packets(input int src, input int first_pkt, input int npkts);
    int   len;
    logic last;
    for (int p = first_pkt; p < first_pkt + npkts; p++) begin
      len = pkt_len(src, p);
      for (int b = 0; b < len; b++) begin
        last = (b == len - 1);
        set_source(src, beat_data(src, p, b), beat_keep(p, last), 1'b1, last);
        @(negedge clk);
        while (!((src == 0) ? s_roce_tready_o : s_bypass_tready_o)) @(negedge clk);
        @(posedge clk);
        #5;
      end
    end
    set_source(src, '0, '0, 1'b0, 1'b0);
  endtask

  task automatic check_beat();
    beat_t got;
    beat_t want;
    int    src;
    got = {m_eth_tlast_o, m_eth_tkeep_o, m_eth_tdata_o};
    src = (m_eth_tdata_o[DATA_WIDTH-1 -: 8] == 8'hC0) ? 0 : 1;
    mon_checks++;
    if (in_pkt && src != cur_src) begin
      mon_errors++;
      $display("Fail %0t: source %0d beat inside a source %0d packet", $time, src, cur_src);
    end
    if ((src == 0 && exp_roce.size() == 0) || (src == 1 && exp_bypass.size() == 0)) begin
      mon_errors++;
      $display("Fail %0t: unexpected beat %h on eth output", $time, got);
    end else begin
      want = (src == 0) ? exp_roce.pop_front() : exp_bypass.pop_front();
      if (got !== want) begin
        mon_errors++;
        $display("Fail %0t: eth beat %h, expected %h", $time, got, want);
      end
    end
    if (m_eth_tlast_o) pkt_order.push_back(src);
    in_pkt = !m_eth_tlast_o;
    cur_src = src;
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rstn && m_eth_tvalid_o && m_eth_tready_i) check_beat();
    if (roce_hold && s_roce_tready_o) begin
      mon_errors++;
      $display("Fail %0t: roce tready high while roce tx is disabled", $time);
    end
  end

  task automatic csr_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    s_csr_waddr_i  = addr;
    s_csr_wdata_i  = data;
    s_csr_wvalid_i = 1'b1;
    @(negedge clk);
    while (!s_csr_wready_o) @(negedge clk);
    @(posedge clk);
    #5;
    s_csr_wvalid_i = 1'b0;
    @(negedge clk);
    while (!s_csr_bvalid_o) @(negedge clk);
    resp = s_csr_bresp_o;
    @(posedge clk);
    #5;
  endtask

  task automatic csr_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    s_csr_araddr_i  = addr;
    s_csr_arvalid_i = 1'b1;
    @(negedge clk);
    while (!s_csr_arready_o) @(negedge clk);
    @(posedge clk);
    #5;
    s_csr_arvalid_i = 1'b0;
    @(negedge clk);
    while (!s_csr_rvalid_o) @(negedge clk);
    data = s_csr_rdata_o;
    resp = s_csr_rresp_o;
    @(posedge clk);
    #5;
  endtask

  task automatic write_expect(input logic [7:0] addr, input logic [31:0] data,
                              input logic [1:0] exp_resp);
    logic [1:0] resp;
    csr_write(addr, data, resp);
    checks++;
    if (resp !== exp_resp) begin
      report_error($sformatf("write 0x%02h resp %0d, expected %0d", addr, resp, exp_resp));
    end
  endtask

  task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp_data,
                             input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0]  resp;
    csr_read(addr, data, resp);
    checks++;
    if (data !== exp_data || resp !== exp_resp) begin
      report_error($sformatf("read 0x%02h gave 0x%08h resp %0d, expected 0x%08h resp %0d",
                             addr, data, resp, exp_data, exp_resp));
    end
  endtask

  task automatic check_drained(input string name);
    checks++;
    if (exp_roce.size() != 0 || exp_bypass.size() != 0) begin
      report_error($sformatf("%s: %0d roce and %0d bypass beats never came out", name,
                             exp_roce.size(), exp_bypass.size()));
    end
  endtask

  task automatic check_order(input int base, input int npkts, input int first_src,
                             input bit alternate);
    int want;
    checks++;
    if (pkt_order.size() - base != npkts) begin
      report_error($sformatf("%0d packets on eth, expected %0d", pkt_order.size() - base,
                             npkts));
    end else begin
      for (int i = 0; i < npkts; i++) begin
        want = alternate ? (first_src ^ (i % 2)) : first_src;
        if (pkt_order[base+i] != want) begin
          report_error($sformatf("packet %0d came from source %0d, expected %0d", i,
                                 pkt_order[base+i], want));
        end
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_start);
    tests++;
    if (error_total() == err_start) $display("%s: passed", name);
    else $display("%s: %0d errors", name, error_total() - err_start);
  endtask

  task automatic csr_access();
    int err_start;
    err_start = error_total();
    checks++;
    if (m_eth_tvalid_o !== 1'b0 || s_roce_tready_o !== 1'b0 || s_bypass_tready_o !== 1'b0 ||
        s_csr_wready_o !== 1'b1 || s_csr_arready_o !== 1'b1 ||
        s_csr_bvalid_o !== 1'b0 || s_csr_rvalid_o !== 1'b0) begin
      report_error("outputs after reset differ from the reset values");
    end
    write_expect(roce_pkg::MAC_LO, 32'h44332211, roce_pkg::OKAY);
    write_expect(roce_pkg::MAC_HI, 32'hABCD6655, roce_pkg::OKAY);
    write_expect(roce_pkg::IPV4, 32'h0A00A8C0, roce_pkg::OKAY);
    write_expect(roce_pkg::CONF, 32'h1, roce_pkg::OKAY);
    read_expect(roce_pkg::MAC_LO, 32'h44332211, roce_pkg::OKAY);
    read_expect(roce_pkg::MAC_HI, 32'h00006655, roce_pkg::OKAY);
    read_expect(roce_pkg::IPV4, 32'h0A00A8C0, roce_pkg::OKAY);
    read_expect(roce_pkg::CONF, 32'h1, roce_pkg::OKAY);
    checks++;
    // network order puts the low register byte in the top bits
    if (my_mac_net_o !== 48'h112233445566 || my_ip_net_o !== 32'hC0A8000A) begin
      report_error($sformatf("net addresses %h %h", my_mac_net_o, my_ip_net_o));
    end
    read_expect(8'h40, 32'h0, roce_pkg::SLVERR);
    write_expect(roce_pkg::CNT_ROCE, 32'h1234, roce_pkg::SLVERR);
    read_expect(roce_pkg::CNT_ROCE, 32'h0, roce_pkg::OKAY);
    finish_test("registers", err_start);
  endtask

  task automatic bypass_only();
    int err_start;
    int base;
    err_start = error_total();
    base = pkt_order.size();
    write_expect(roce_pkg::CONF, 32'h0, roce_pkg::OKAY);
    // roce keeps a beat pending the whole time
    roce_hold = 1'b1;
    set_source(0, beat_data(0, 999, 0), '1, 1'b1, 1'b1);
    queue_packets(1, 0, 5);
    drive_packets(1, 0, 5);
    idle_cycles(3);
    set_source(0, '0, '0, 1'b0, 1'b0);
    roce_hold = 1'b0;
    check_drained("bypass only");
    check_order(base, 5, 1, 1'b0);
    finish_test("bypass only", err_start);
  endtask

  task automatic round_robin();
    int err_start;
    int base;
    err_start = error_total();
    base = pkt_order.size();
    write_expect(roce_pkg::CONF, 32'h1, roce_pkg::OKAY);
    queue_packets(0, 0, 6);
    queue_packets(1, 100, 6);
    fork
      drive_packets(0, 0, 6);
      drive_packets(1, 100, 6);
    join
    idle_cycles(2);
    check_drained("round robin");
    check_order(base, 12, 0, 1'b1);
    finish_test("round robin", err_start);
  endtask

  task automatic back_pressure();
    int err_start;
    int base;
    err_start = error_total();
    base = pkt_order.size();
    random_ready = 1'b1;
    queue_packets(0, 200, 8);
    queue_packets(1, 300, 8);
    fork
      drive_packets(0, 200, 8);
      drive_packets(1, 300, 8);
    join
    idle_cycles(2);
    random_ready = 1'b0;
    idle_cycles(1);
    check_drained("back pressure");
    checks++;
    if (pkt_order.size() - base != 16) begin
      report_error($sformatf("%0d packets under back pressure, expected 16",
                             pkt_order.size() - base));
    end
    finish_test("back pressure", err_start);
  endtask

  task automatic packet_counts();
    int err_start;
    err_start = error_total();
    read_expect(roce_pkg::CNT_ROCE, sent_roce, roce_pkg::OKAY);
    read_expect(roce_pkg::CNT_BYPASS, sent_bypass, roce_pkg::OKAY);
    write_expect(roce_pkg::CNT_CLEAR, 32'h1, roce_pkg::OKAY);
    read_expect(roce_pkg::CNT_ROCE, 32'h0, roce_pkg::OKAY);
    read_expect(roce_pkg::CNT_BYPASS, 32'h0, roce_pkg::OKAY);
    finish_test("counters", err_start);
  endtask

  initial begin
    seed = 54674;
    rstn = 1'b0;
    random_ready = 1'b0;
    roce_hold = 1'b0;
    set_source(0, '0, '0, 1'b0, 1'b0);
    set_source(1, '0, '0, 1'b0, 1'b0);
    s_csr_wvalid_i = 1'b0;
    s_csr_waddr_i = '0;
    s_csr_wdata_i = '0;
    s_csr_bready_i = 1'b1;
    s_csr_arvalid_i = 1'b0;
    s_csr_araddr_i = '0;
    s_csr_rready_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #5;
    rstn = 1'b1;
    idle_cycles(1);
    csr_access();
    bypass_only();
    round_robin();
    back_pressure();
    packet_counts();
    $display("tests %0d, checks %0d, errors %0d", tests, checks + mon_checks, error_total());
    if (error_total() == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", LIMIT_CYCLES);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* tx_path/tx_arbiter_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module tx_arbiter_fsm #(
  parameter int unsigned DATA_WIDTH = roce_pkg::AXIS_DATA_WIDTH
)(
  input  logic                 axis_aclk_i,
  input  logic                 axis_rstn_i,
  axis_if.snk                  roce_i,
  axis_if.snk                  bypass_i,
  axis_if.snk                  eth_i,
  input  logic                 roce_tx_en_i,
  output roce_pkg::arb_state_e grant_o,
  output logic                 pkt_done_o
);

  roce_pkg::arb_state_e state_q;
  roce_pkg::arb_state_e state_d;
  logic                 last_roce_q;
  logic                 last_roce_d;
  logic                 roce_req;
  logic                 bypass_req;
  logic                 eop_accept;

  // roce only competes while transmission is enabled
  assign roce_req   = roce_i.tvalid & roce_tx_en_i;
  assign bypass_req = bypass_i.tvalid;
  assign eop_accept = eth_i.tvalid & eth_i.tready & eth_i.tlast;

  always_comb begin
    state_d     = state_q;
    last_roce_d = last_roce_q;
    case (state_q)
      roce_pkg::IDLE: begin
        if (roce_req && (!bypass_req || !last_roce_q)) begin
          state_d     = roce_pkg::GRANT_ROCE;
          last_roce_d = 1'b1;
        end else if (bypass_req) begin
          state_d     = roce_pkg::GRANT_BYPASS;
          last_roce_d = 1'b0;
        end
      end
      // hold the grant until the last beat leaves
      roce_pkg::GRANT_ROCE,
      roce_pkg::GRANT_BYPASS: begin
        if (eop_accept) begin
          state_d = roce_pkg::IDLE;
        end
      end
      default: begin
        state_d = roce_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge axis_aclk_i, negedge axis_rstn_i) begin
    if (!axis_rstn_i) begin
      state_q     <= roce_pkg::IDLE;
      // bypass counts as last grant so roce wins the first tie
      last_roce_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      last_roce_q <= last_roce_d;
    end
  end

  assign grant_o    = state_q;
  assign pkt_done_o = (state_q != roce_pkg::IDLE) & eop_accept;

endmodule

`default_nettype wire

/* tx_path/tx_stream_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module tx_stream_mux #(
  parameter int unsigned DATA_WIDTH = roce_pkg::AXIS_DATA_WIDTH
)(
  input  roce_pkg::arb_state_e grant_i,
  axis_if.snk                  roce_s,
  axis_if.snk                  bypass_s,
  axis_if.src                  eth_m
);

  logic [DATA_WIDTH-1:0]   sel_tdata;
  logic [DATA_WIDTH/8-1:0] sel_tkeep;
  logic                    sel_tlast;
  logic                    sel_tvalid;

  always_comb begin
    // payload follows roce unless bypass holds the grant
    sel_tdata       = roce_s.tdata;
    sel_tkeep       = roce_s.tkeep;
    sel_tlast       = roce_s.tlast;
    sel_tvalid      = 1'b0;
    roce_s.tready   = 1'b0;
    bypass_s.tready = 1'b0;
    case (grant_i)
      roce_pkg::GRANT_ROCE: begin
        sel_tvalid    = roce_s.tvalid;
        roce_s.tready = eth_m.tready;
      end
      roce_pkg::GRANT_BYPASS: begin
        sel_tdata       = bypass_s.tdata;
        sel_tkeep       = bypass_s.tkeep;
        sel_tlast       = bypass_s.tlast;
        sel_tvalid      = bypass_s.tvalid;
        bypass_s.tready = eth_m.tready;
      end
      default: begin
        sel_tvalid = 1'b0;
      end
    endcase
  end

  assign eth_m.tdata  = sel_tdata;
  assign eth_m.tkeep  = sel_tkeep;
  assign eth_m.tlast  = sel_tlast;
  assign eth_m.tvalid = sel_tvalid;

endmodule

`default_nettype wire
